// File: approxMultiplier.f
source/multTypesPkg.sv
source/approxCfgPkg.sv
source/operandStage.sv
source/carrySaveRow.sv
source/ppArray.sv
source/finalStage.sv
source/approxMultiplier.sv
tb/tbClockGen.sv
tb/approxMultiplier_props.sv
tb/approxMultiplier_tb.sv

// File: source/approxCfgPkg.sv
`default_nettype none

package approxCfgPkg;

    localparam int dropRows = 1; // low multiplier rows left out
    localparam int dropCols = 2; // columns below this weight left out

    // first kept bit position inside a row, so that row + col reaches dropCols
    function automatic int firstKeptCol(input int row);
        return (row >= dropCols) ? 0 : dropCols - row;
    endfunction

    // keep rule for partial product a[col] & b[row]
    function automatic bit keepBit(input int row, input int col);
        return (row >= dropRows) && (col >= firstKeptCol(row));
    endfunction

endpackage

`default_nettype wire

// File: source/approxMultiplier.sv
`timescale 1ns/1ps
`default_nettype none

module approxMultiplier
    import multTypesPkg::*;
(
    input  logic     clk,
    input  logic     rstN,
    input  logic     inValid,
    input  operand_t opA,
    input  operand_t opB,
    output logic     outValid,
    output product_t product
);

    operandPair_t sortedPair;
    logic         pairValid;
    rowState_t    lastRow;
    rowSum_t      lowBits;

    operandStage u_operandStage (
        .clk        (clk),
        .rstN       (rstN),
        .inValid    (inValid),
        .opA        (opA),
        .opB        (opB),
        .sortedPair (sortedPair),
        .pairValid  (pairValid)
    );

    // combinational, between the two registers
    ppArray u_ppArray (
        .pair    (sortedPair),
        .lastRow (lastRow),
        .lowBits (lowBits)
    );

    finalStage u_finalStage (
        .clk       (clk),
        .rstN      (rstN),
        .pairValid (pairValid),
        .lastRow   (lastRow),
        .lowBits   (lowBits),
        .product   (product),
        .outValid  (outValid)
    );

endmodule

`default_nettype wire

// File: source/carrySaveRow.sv
`timescale 1ns/1ps
`default_nettype none

module carrySaveRow
    import multTypesPkg::*, approxCfgPkg::*;
#(
    parameter int rowIndex = 1
)
(
    input  operand_t  a,
    input  logic      bBit,
    input  rowState_t rowIn,
    output rowState_t rowOut,
    output logic      lowBit
);

    logic [operandWidth-1:0] pp;
    rowSum_t                 sumNext;
    rowCarry_t               carryNext;

    genvar j;
    generate
        for (j = 0; j < operandWidth; j++)
        begin : genGate
            if (keepBit(rowIndex, j))
            begin : genKeep
                assign pp[j] = a[j] & bBit;
            end
            else
            begin : genDrop
                assign pp[j] = 1'b0; // omitted partial product
            end
        end
    endgenerate

    genvar m;
    generate
        for (m = 0; m < operandWidth-1; m++)
        begin : genCell
            logic x;
            logic y;
            logic z;

            assign x = pp[m];
            assign y = rowIn.carry[m];
            assign z = rowIn.sum[m+1]; // previous sum shifted down one column

            assign sumNext[m]   = x ^ y ^ z;
            assign carryNext[m] = (x & y) | (x & z) | (y & z);
        end
    endgenerate

    // nothing else lands in the top column of a row
    assign sumNext[operandWidth-1] = pp[operandWidth-1];

    assign rowOut.sum   = sumNext;
    assign rowOut.carry = carryNext;
    assign lowBit       = sumNext[0]; // this column is final

endmodule

`default_nettype wire

// File: source/finalStage.sv
`timescale 1ns/1ps
`default_nettype none

module finalStage
    import multTypesPkg::*;
(
    input  logic      clk,
    input  logic      rstN,
    input  logic      pairValid,
    input  rowState_t lastRow,
    input  rowSum_t   lowBits,
    output product_t  product,
    output logic      outValid
);

    rowSum_t  upper;
    logic     rippleCarry;
    product_t productNext;

    // ripple add of the last carry vector into the shifted last sum
    always_comb
    begin
        rippleCarry = 1'b0;
        for (int m = 0; m < operandWidth-1; m++)
        begin
            upper[m]    = lastRow.carry[m] ^ lastRow.sum[m+1] ^ rippleCarry;
            rippleCarry = (lastRow.carry[m] & lastRow.sum[m+1])
                        | (lastRow.carry[m] & rippleCarry)
                        | (lastRow.sum[m+1] & rippleCarry);
        end
        upper[operandWidth-1] = rippleCarry; // top product bit
    end

    assign productNext = {upper, lowBits};

    always_ff @(posedge clk or negedge rstN)
    begin
        if (!rstN)
        begin
            product  <= '0;
            outValid <= 1'b0;
        end
        else
        begin
            outValid <= pairValid;
            if (pairValid)
            begin
                product <= productNext;
            end
        end
    end

endmodule

`default_nettype wire

// File: source/multTypesPkg.sv
`default_nettype none

package multTypesPkg;

    localparam int operandWidth = 16;

    typedef logic [operandWidth-1:0]   operand_t;
    typedef logic [2*operandWidth-1:0] product_t;
    typedef logic [operandWidth-1:0]   rowSum_t;
    typedef logic [operandWidth-2:0]   rowCarry_t; // no carry out of the top column

    typedef struct packed
    {
        operand_t a; // multiplicand, the larger one
        operand_t b; // multiplier
    } operandPair_t;

    // running state handed from one array row to the next
    typedef struct packed
    {
        rowSum_t   sum;
        rowCarry_t carry; // carry[m] weighs one column above sum[m]
    } rowState_t;

endpackage

`default_nettype wire

// File: source/operandStage.sv
`timescale 1ns/1ps
`default_nettype none

module operandStage
    import multTypesPkg::*;
(
    input  logic         clk,
    input  logic         rstN,
    input  logic         inValid,
    input  operand_t     opA,
    input  operand_t     opB,
    output operandPair_t sortedPair,
    output logic         pairValid
);

    logic         aIsLarger;
    operandPair_t orderedPair;

    assign aIsLarger = (opA >= opB); // ties keep the given order

    always_comb
    begin
        if (aIsLarger)
        begin
            orderedPair.a = opA;
            orderedPair.b = opB;
        end
        else
        begin
            orderedPair.a = opB;
            orderedPair.b = opA;
        end
    end

    always_ff @(posedge clk or negedge rstN)
    begin
        if (!rstN)
        begin
            sortedPair <= '0;
            pairValid  <= 1'b0;
        end
        else
        begin
            pairValid <= inValid;
            if (inValid)
            begin
                sortedPair <= orderedPair; // hold the last pair otherwise
            end
        end
    end

endmodule

`default_nettype wire

// File: source/ppArray.sv
`timescale 1ns/1ps
`default_nettype none

module ppArray
    import multTypesPkg::*, approxCfgPkg::*;
(
    input  operandPair_t pair,
    output rowState_t    lastRow,
    output rowSum_t      lowBits
);

    rowState_t               chain [operandWidth];
    logic [operandWidth-1:0] row0Pp;
    rowSum_t                 retired;

    genvar j;
    generate
        for (j = 0; j < operandWidth; j++)
        begin : genRow0
            if (keepBit(0, j))
            begin : genKeep
                assign row0Pp[j] = pair.a[j] & pair.b[0];
            end
            else
            begin : genDrop
                assign row0Pp[j] = 1'b0;
            end
        end
    endgenerate

    // row 0 has only partial products, no carries yet
    assign chain[0].sum   = row0Pp;
    assign chain[0].carry = '0;
    assign retired[0]     = row0Pp[0];

    genvar i;
    generate
        for (i = 1; i < operandWidth; i++)
        begin : genRow
            carrySaveRow #(
                .rowIndex (i)
            ) u_carrySaveRow (
                .a      (pair.a),
                .bBit   (pair.b[i]),
                .rowIn  (chain[i-1]),
                .rowOut (chain[i]),
                .lowBit (retired[i])
            );
        end
    endgenerate

    assign lastRow = chain[operandWidth-1];
    assign lowBits = retired;

endmodule

`default_nettype wire

// File: tb/approxMultiplier_props.sv
`timescale 1ns/1ps
`default_nettype none

module approxMultiplier_props
(
    input logic clk,
    input logic rstN,
    input logic inValid,
    input logic outValid
);

    resetQuiet: assert property (@(posedge clk) !rstN |-> !outValid)
        else $error("outValid high during reset");

    // every accepted pair leaves two cycles later
    validToOut: assert property (@(posedge clk) disable iff (!rstN)
        inValid |-> ##2 outValid)
        else $error("outValid missing two cycles after inValid");

    outFromValid: assert property (@(posedge clk) disable iff (!rstN)
        outValid |-> $past(inValid, 2))
        else $error("outValid without inValid two cycles before");

endmodule

bind approxMultiplier approxMultiplier_props u_props (
    .clk      (clk),
    .rstN     (rstN),
    .inValid  (inValid),
    .outValid (outValid)
);

`default_nettype wire

// File: tb/approxMultiplier_tb.sv
`timescale 1ns/1ps
`default_nettype none

module approxMultiplier_tb
    import multTypesPkg::*, approxCfgPkg::*;
();

    localparam int resetCycles = 16;
    localparam int idleCycles  = 2;
    localparam int numDirected = 12;
    localparam int numRandom   = 2000;
    localparam int numStream   = 64;
    localparam int drainCycles = 6;
    // each random pair goes twice, each send may be followed by a gap
    localparam int cycleLimit  = resetCycles + idleCycles + numDirected + 4*numRandom
                               + numStream + drainCycles + 100;

    logic     clk;
    logic     rstN;
    logic     inValid;
    operand_t opA;
    operand_t opB;
    logic     outValid;
    product_t product;

    product_t    expQueue [$];
    product_t    expProduct;
    logic [1:0]  validHist = '0;
    logic [31:0] lfsrState = 32'hce8d_af03;
    int          cycleCount = 0;

    tbClockGen u_tbClockGen (
        .clk (clk)
    );

    approxMultiplier i_approxMultiplier (
        .clk      (clk),
        .rstN     (rstN),
        .inValid  (inValid),
        .opA      (opA),
        .opB      (opB),
        .outValid (outValid),
        .product  (product)
    );

    task automatic failRun(input string why);
        $display("%s", why);
        $display("*** TEST FAILED ***");
        $fatal(1);
    endtask

    task automatic checkProduct(input string name, input product_t got, input product_t exp);
        if (got !== exp)
            failRun($sformatf("Error: %s is 0x%h, expected 0x%h", name, got, exp));
    endtask

    task automatic checkBit(input string name, input logic got, input logic exp);
        if (got !== exp)
            failRun($sformatf("Error: %s is 0x%h, expected 0x%h", name, got, exp));
    endtask

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] nextLfsr(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic takeBits(input int count, output logic [31:0] bits);
        bits = '0;
        for (int k = 0; k < count; k++)
        begin
            lfsrState = nextLfsr(lfsrState); // one step per bit
            bits      = {bits[30:0], lfsrState[0]};
        end
    endtask

    task automatic randomOperand(output operand_t op);
        logic [31:0] bits;
        takeBits(operandWidth, bits);
        op = bits[operandWidth-1:0];
    endtask

    // sum of the kept partial products, larger operand as multiplicand
    function automatic product_t modelProduct(input operand_t x, input operand_t y);
        operand_t mcand;
        operand_t mplier;
        product_t acc;
        mcand  = (x >= y) ? x : y;
        mplier = (x >= y) ? y : x;
        acc    = '0;
        for (int i = 0; i < operandWidth; i++)
        begin
            for (int j = 0; j < operandWidth; j++)
            begin
                if (i >= dropRows && i + j >= dropCols && mcand[j] && mplier[i])
                    acc = acc + (product_t'(1) << (i + j));
            end
        end
        return acc;
    endfunction

    task automatic sendPairExpect(input operand_t x, input operand_t y, input product_t exp);
        opA     = x;
        opB     = y;
        inValid = 1'b1;
        expQueue.push_back(exp);
        @(posedge clk);
        #5;
    endtask

    task automatic sendPair(input operand_t x, input operand_t y);
        sendPairExpect(x, y, modelProduct(x, y));
    endtask

    task automatic sendGap();
        inValid = 1'b0;
        @(posedge clk);
        #5;
    endtask

    task automatic maybeGap();
        logic [31:0] bits;
        takeBits(1, bits);
        if (bits[0])
            sendGap();
    endtask

    // outputs checked mid-cycle, away from both edges
    always @(negedge clk)
    begin
        if (cycleCount > 0) // checks start after the first rising edge
        begin
            checkBit("outValid", outValid, validHist[1]);
            if (validHist[1])
            begin
                if (expQueue.size() == 0)
                    failRun("outValid predicted but no result was queued");
                else
                begin
                    expProduct = expQueue.pop_front();
                    checkProduct("product", product, expProduct);
                end
            end
            validHist = {validHist[0], inValid}; // inValid seen here is sampled next edge
        end
    end

    always @(posedge clk)
    begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= cycleLimit)
            failRun($sformatf("run timed out after %0d cycles, %0d results outstanding",
                              cycleCount, expQueue.size()));
    end

    initial
    begin
        operand_t x;
        operand_t y;
        product_t exp;
        rstN    = 1'b1;
        inValid = 1'b0;
        opA     = '0;
        opB     = '0;
        #1;
        rstN = 1'b0; // falling edge well before the first clock
        repeat (resetCycles) @(posedge clk);
        #5;
        rstN = 1'b1;
        repeat (idleCycles) sendGap();

        sendPairExpect(16'h0000, 16'h0000, '0);
        sendPairExpect(16'h0000, 16'hffff, '0);
        sendPairExpect(16'h1234, 16'h0000, '0);
        sendPairExpect(16'h0001, 16'h0001, '0); // lone bit sits in row 0
        sendPair(16'hffff, 16'hffff);
        sendPair(16'hffff, 16'h8000);
        sendPair(16'h0001, 16'hffff);
        sendPair(16'hffff, 16'h0001);
        sendPair(16'h4000, 16'hffff);
        sendPair(16'ha5a5, 16'ha5a5);
        sendPair(16'h0003, 16'h0003);
        sendPair(16'h7fff, 16'h7fff);

        for (int k = 0; k < numRandom; k++)
        begin
            randomOperand(x);
            randomOperand(y);
            exp = modelProduct(x, y);
            sendPairExpect(x, y, exp);
            maybeGap();
            sendPairExpect(y, x, exp); // swapped must match
            maybeGap();
        end

        for (int k = 0; k < numStream; k++)
        begin
            randomOperand(x);
            randomOperand(y);
            sendPair(x, y);
        end
        sendGap();

        while (expQueue.size() != 0)
            @(posedge clk);
        repeat (3) @(posedge clk);

        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire

// File: tb/tbClockGen.sv
`timescale 1ns/1ps
`default_nettype none

module tbClockGen
(
    output logic clk
);

    localparam realtime halfPeriod = 50ns; // 100 ns period

    initial
    begin
        clk = 1'b0;
    end

    always #(halfPeriod) clk = ~clk;

endmodule

`default_nettype wire
